//--- Makefile
SIM := obj_dir/Vtb_video_gen

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

$(SIM): build.f $(shell cat build.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_video_gen -f build.f

clean:
	rm -rf obj_dir

//--- build.f
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_config_regs.sv
verilog/text_fetch.sv
verilog/pixel_color.sv
verilog/video_gen.sv
sim/tb_video_gen.sv

//--- sim/tb_video_gen.sv
`default_nettype none
`timescale 1ns/1ns

module tb_video_gen;

    localparam int H_VISIBLE  = 64;
    localparam int H_FRONT    = 8;
    localparam int H_SYNC     = 8;
    localparam int H_BACK     = 16;
    localparam int V_VISIBLE  = 32;
    localparam int V_FRONT    = 2;
    localparam int V_SYNC     = 2;
    localparam int V_BACK     = 4;
    localparam bit H_SYNC_POL = 1'b0;                   // both syncs active low
    localparam bit V_SYNC_POL = 1'b0;
    localparam int H_OFF      = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL    = H_OFF + H_VISIBLE;      // 96 clocks per line
    localparam int V_TOTAL    = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD = 40;
    localparam int VSEL_H     = H_OFF - 4;              // first vram select of a line

    logic        clk = 1'b0;
    logic        reset_i;
    logic        enable_i;
    logic        config_wr_i;
    logic [1:0]  config_num_i;
    logic [15:0] config_data_i;
    logic [15:0] vram_data_i;
    logic [7:0]  font_data_i;
    wire         vram_sel_o;
    wire         font_sel_o;
    wire  [15:0] vram_addr_o;
    wire  [12:0] font_addr_o;
    wire  [3:0]  red_o;
    wire  [3:0]  green_o;
    wire  [3:0]  blue_o;
    wire         hsync_o;
    wire         vsync_o;
    wire         dv_de_o;

    logic [15:0] vram_mem [65536];
    logic [7:0]  font_mem [8192];
    logic [11:0] pal_rom [16] = '{12'h000, 12'h00A, 12'h0A0, 12'h0AA, 12'hA00, 12'hA0A,
                                  12'hAA0, 12'hAAA, 12'h555, 12'h55F, 12'h5F5, 12'h5FF,
                                  12'hF55, 12'hF5F, 12'hFF5, 12'hFFF};

    int unsigned rng_state = 24;                        // lcg seed
    int unsigned pos;                                   // position whose pixel is on the outputs
    bit          started = 1'b0;
    int          frames = 0;                            // completed frames
    bit          frame_en = 1'b0;                       // enable latched at frame end
    bit          out_en;
    logic [15:0] cfg_start = 16'd0;                     // shadow of the config registers
    logic [15:0] cfg_width = 16'(H_VISIBLE / 8);
    logic [3:0]  cfg_scroll = 4'd0;
    logic [3:0]  cfg_height = 4'd15;
    logic        cfg_bank = 1'b0;
    logic [15:0] frame_start = 16'd0;
    logic [15:0] out_start;
    logic [3:0]  frame_scroll = 4'd0;
    logic [3:0]  out_scroll;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          hs_count = 0;
    int          vs_count = 0;
    int          de_count = 0;

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
    ) UUT (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .config_wr_i(config_wr_i),
        .config_num_i(config_num_i), .config_data_i(config_data_i),
        .vram_data_i(vram_data_i), .font_data_i(font_data_i),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
        .font_sel_o(font_sel_o), .font_addr_o(font_addr_o),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o));

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // text word address of visible pixel x on line y
    function automatic logic [15:0] char_addr(input int x, input int y);
        int fl_lin;
        int row;
        fl_lin = int'(out_scroll) + y;                  // scroll shifts the first cell row
        row    = fl_lin / (int'(cfg_height) + 1);
        return 16'(int'(out_start) + row * int'(cfg_width) + x / 8);
    endfunction

    function automatic logic [3:0] font_line_of(input int y);
        return 4'((int'(out_scroll) + y) % (int'(cfg_height) + 1));
    endfunction

    // colour of visible pixel x on line y from the text, font and palette tables
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        logic [15:0] word;
        logic [7:0]  pattern;
        logic [3:0]  idx;
        word    = vram_mem[char_addr(x, y)];
        pattern = font_mem[{cfg_bank, word[7:0], font_line_of(y)}];
        idx     = pattern[7 - x % 8] ? word[11:8] : word[15:12];   // fg when set
        return pal_rom[idx];
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("ERROR %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic write_reg(input logic [1:0] num, input logic [15:0] data);
        @(negedge clk);
        config_wr_i   <= 1'b1;                          // one clock strobe
        config_num_i  <= num;
        config_data_i <= data;
        @(negedge clk);
        config_wr_i   <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_base);
        tests_run++;
        if (errors == err_base) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_base);
        end
    endtask

    // synchronous memories answer a select seen at the last rising edge
    always @(negedge clk) begin
        if (font_sel_o) font_data_i <= font_mem[font_addr_o];
        if (vram_sel_o) vram_data_i <= vram_mem[vram_addr_o];
    end

    // outputs lag the timing by one clock, so track the position processed at each edge
    always @(posedge clk) begin
        if (reset_i) begin
            started = 1'b0;
        end else begin
            pos        = started ? pos + 1 : 0;
            started    = 1'b1;
            out_en     = frame_en;
            out_start  = frame_start;
            out_scroll = frame_scroll;
            if (pos % FRAME_CLKS == FRAME_CLKS - 1) begin
                frame_en     = enable_i;                // next frame follows enable
                frame_start  = cfg_start;
                frame_scroll = cfg_scroll;
                frames++;
            end
        end
    end

    always @(negedge clk) begin : monitor
        int          h;
        int          line;
        int          cell_x;
        logic        exp_de;
        logic [11:0] exp_rgb;
        logic [11:0] got_rgb;
        logic [15:0] exp_addr;
        logic [12:0] exp_font;
        if (started) begin
            h       = pos % H_TOTAL;
            line    = (pos / H_TOTAL) % V_TOTAL;
            exp_de  = out_en && h >= H_OFF && line < V_VISIBLE;
            got_rgb = {red_o, green_o, blue_o};
            exp_rgb = exp_de ? expected_rgb(h - H_OFF, line) : 12'h000;   // black outside
            if (dv_de_o !== exp_de) report_mismatch("dv_de_o", dv_de_o, exp_de);
            if (got_rgb !== exp_rgb) report_mismatch("rgb", got_rgb, exp_rgb);
            if (!out_en && (vram_sel_o || font_sel_o)) begin
                report_problem("memory select raised while the display is disabled");
            end
            if (vram_sel_o && h >= VSEL_H && line < V_VISIBLE) begin
                cell_x   = ((h - VSEL_H) / 8) * 8;
                exp_addr = char_addr(cell_x, line);
                if (vram_addr_o !== exp_addr) begin
                    report_mismatch("vram_addr_o", vram_addr_o, exp_addr);
                end
            end
            if (font_sel_o && h > VSEL_H && line < V_VISIBLE) begin
                cell_x   = ((h - VSEL_H - 1) / 8) * 8;
                exp_addr = char_addr(cell_x, line);
                exp_font = {cfg_bank, vram_mem[exp_addr][7:0], font_line_of(line)};
                if (font_addr_o !== exp_font) begin
                    report_mismatch("font_addr_o", font_addr_o, exp_font);
                end
            end
            if (hsync_o == H_SYNC_POL) hs_count++;
            if (vsync_o == V_SYNC_POL) vs_count++;
            if (dv_de_o) de_count++;
            if (h == H_TOTAL - 1) begin
                if (hs_count != H_SYNC) report_mismatch("hsync_o clocks", hs_count, H_SYNC);
                hs_count = 0;
            end
            if (pos % FRAME_CLKS == FRAME_CLKS - 1) begin
                if (vs_count != V_SYNC * H_TOTAL) begin
                    report_mismatch("vsync_o clocks", vs_count, V_SYNC * H_TOTAL);
                end
                if (de_count != (out_en ? H_VISIBLE * V_VISIBLE : 0)) begin
                    report_mismatch("dv_de_o clocks", de_count, out_en ? H_VISIBLE * V_VISIBLE : 0);
                end
                vs_count = 0;
                de_count = 0;
            end
        end
    end

    initial begin
        int base;
        reset_i       = 1'b1;
        enable_i      = 1'b1;
        config_wr_i   = 1'b0;
        config_num_i  = 2'd0;
        config_data_i = 16'd0;
        vram_data_i   = 16'd0;
        font_data_i   = 8'd0;
        for (int i = 0; i < 65536; i++) vram_mem[i] = 16'(next_rand() >> 8);
        for (int i = 0; i < 8192; i++) font_mem[i] = 8'(next_rand() >> 16);
        repeat (2) @(negedge clk);
        reset_i <= 1'b0;
        base = errors;                                  // frame 0 stays dark after reset
        wait (frames >= 1);
        finish_test("sync shape", base);
        base = errors;
        wait (frames >= 2);
        finish_test("display enable", base);
        base = errors;
        wait (frames >= 3);
        finish_test("pixel colours", base);
        base = errors;
        @(negedge clk);
        enable_i <= 1'b0;                               // frame 4 goes dark
        wait (frames >= 4);
        @(negedge clk);
        enable_i <= 1'b1;                               // frame 5 lights up again
        wait (frames >= 6);
        finish_test("enable at frame boundary", base);
        base = errors;
        wait ((pos / H_TOTAL) % V_TOTAL == V_VISIBLE + 1);   // vertical blanking of frame 6
        cfg_start  = 16'(next_rand() >> 12);
        cfg_width  = 16'(1 + next_rand() % 40);
        cfg_height = 4'(7 + next_rand() % 9);
        cfg_scroll = 4'(next_rand() % (cfg_height + 1));
        cfg_bank   = 1'b1;
        write_reg(video_pkg::REG_TEXT_START, cfg_start);
        write_reg(video_pkg::REG_LINE_WIDTH, cfg_width);
        write_reg(video_pkg::REG_SCROLL, {12'd0, cfg_scroll});
        write_reg(video_pkg::REG_FONT, {7'd0, cfg_bank, 4'd0, cfg_height});
        wait (frames >= 8);
        finish_test("configuration writes", base);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(12 * FRAME_CLKS * CLK_PERIOD);                // eight frames needed, twelve allowed
        $display("watchdog timeout, the tests did not finish within 12 frames");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pixel_color.sv
`default_nettype none
`timescale 1ns/1ns

module pixel_color #(
    parameter bit H_SYNC_POL = 1'b0,                    // level while in sync
    parameter bit V_SYNC_POL = 1'b0
) (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire video_pkg::timing_ev_t ev_i,
    input  wire                     text_en_i,
    input  wire                     pix_i,              // current pattern bit
    input  wire  [7:0]              attr_i,             // {bg, fg}
    output video_pkg::rgb_t         rgb_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);

    logic                  de;
    video_pkg::color_idx_t idx;

    // classic 16 colour text palette, 4 bits per channel
    function automatic video_pkg::rgb_t palette(input video_pkg::color_idx_t c);
        case (c)
            4'd0:  return 12'h000;                      // black
            4'd1:  return 12'h00A;
            4'd2:  return 12'h0A0;
            4'd3:  return 12'h0AA;
            4'd4:  return 12'hA00;
            4'd5:  return 12'hA0A;
            4'd6:  return 12'hAA0;                      // brown
            4'd7:  return 12'hAAA;
            4'd8:  return 12'h555;                      // dark gray
            4'd9:  return 12'h55F;
            4'd10: return 12'h5F5;
            4'd11: return 12'h5FF;
            4'd12: return 12'hF55;
            4'd13: return 12'hF5F;
            4'd14: return 12'hFF5;                      // yellow
            4'd15: return 12'hFFF;
        endcase
    endfunction

    always_comb begin
        de  = ev_i.visible && text_en_i;
        idx = pix_i ? attr_i[3:0] : attr_i[7:4];        // fg on set pixel
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rgb_o   <= '0;
            dv_de_o <= 1'b0;
            hsync_o <= ~H_SYNC_POL;                     // idle level right away
            vsync_o <= ~V_SYNC_POL;
        end else begin
            rgb_o   <= de ? palette(idx) : '0;          // black in blanking
            dv_de_o <= de;
            hsync_o <= ev_i.hsync ? H_SYNC_POL : ~H_SYNC_POL;
            vsync_o <= ev_i.vsync ? V_SYNC_POL : ~V_SYNC_POL;
        end
    end

endmodule

`default_nettype wire

//--- verilog/text_fetch.sv
`default_nettype none
`timescale 1ns/1ns

module text_fetch (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     enable_i,           // sampled once per frame
    input  wire video_pkg::timing_ev_t ev_i,
    input  wire video_pkg::video_cfg_t cfg_i,
    input  wire video_pkg::vram_word_t vram_data_i,
    input  wire video_pkg::font_byte_t font_data_i,
    output logic                    vram_sel_o,
    output logic                    font_sel_o,
    output video_pkg::vram_addr_t   vram_addr_o,
    output video_pkg::font_addr_t   font_addr_o,
    output logic                    text_en_o,
    output logic                    pix_o,
    output logic [7:0]              attr_o
);

    logic [2:0]              col_q;                     // cell column register
    logic [2:0]              col;                       // column seen this clock
    logic                    active;                    // fetching for an enabled frame
    logic                    tg_en;                     // frame-stable enable
    video_pkg::font_line_t   font_line;
    video_pkg::vram_addr_t   text_addr;                 // next char+attr word
    video_pkg::vram_addr_t   line_addr;                 // first word of current text row
    logic [7:0]              attr_next;                 // attribute waiting for its pattern
    logic [7:0]              attr;                      // attribute of the cell on screen
    video_pkg::font_byte_t   shifter;

    always_comb begin
        col    = ev_i.fetch_start ? 3'd0 : col_q;       // window start realigns the cell
        active = tg_en && ev_i.fetch;
    end

    assign font_addr_o = {cfg_i.font_bank, vram_data_i[7:0], font_line};  // no lookup cycle
    assign text_en_o   = tg_en;
    assign pix_o       = shifter[7];
    assign attr_o      = attr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            col_q      <= '0;
            tg_en      <= 1'b0;
            font_line  <= '0;
            text_addr  <= '0;
            line_addr  <= '0;
            vram_sel_o <= 1'b0;
            font_sel_o <= 1'b0;
        end else begin
            col_q      <= col + 3'd1;
            vram_sel_o <= active && (col == 3'd4);      // high through column 5
            font_sel_o <= active && (col == 3'd5);      // word is on the bus in column 6
            if (active && col == 3'd7) begin
                text_addr <= text_addr + video_pkg::vram_addr_t'(1);
            end
            if (ev_i.line_end) begin
                if (font_line == cfg_i.font_height) begin
                    font_line <= '0;                    // next text row
                    line_addr <= line_addr + cfg_i.line_width;
                    text_addr <= line_addr + cfg_i.line_width;
                end else begin
                    font_line <= font_line + 4'd1;
                    text_addr <= line_addr;             // same row again
                end
            end
            if (ev_i.frame_end) begin                   // wins over line_end
                tg_en     <= enable_i;
                font_line <= cfg_i.fine_scrolly;
                text_addr <= cfg_i.text_start;
                line_addr <= cfg_i.text_start;
            end
        end
    end

    always_ff @(posedge clk) begin
        shifter <= {shifter[6:0], 1'b0};                // one pixel per clock
        if (active && col == 3'd4) begin
            vram_addr_o <= text_addr;
        end
        if (active && col == 3'd6) begin
            attr_next <= vram_data_i[15:8];             // bg/fg nibbles
        end
        if (active && col == 3'd7) begin
            shifter <= font_data_i;                     // pattern for the next eight pixels
            attr    <= attr_next;
        end
    end

    a_sel_in_window: assert property (@(posedge clk) disable iff (reset_i)
        (vram_sel_o || font_sel_o) |-> (ev_i.fetch && tg_en));

endmodule

`default_nettype wire

//--- verilog/video_config_regs.sv
`default_nettype none
`timescale 1ns/1ns

module video_config_regs #(
    parameter int RESET_LINE_WIDTH = 8                  // chars per row after reset
) (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     config_wr_i,        // single clock write strobe
    input  wire  [1:0]              config_num_i,       // register select
    input  wire  [15:0]             config_data_i,
    output video_pkg::video_cfg_t   cfg_o
);

    // start and scroll are picked up by the fetch engine at frame end,
    // width and font height act on the next line end
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o.text_start   <= '0;                   // top of vram
            cfg_o.line_width   <= 16'(RESET_LINE_WIDTH);
            cfg_o.fine_scrolly <= '0;
            cfg_o.font_height  <= 4'd15;                // 8x16 cells
            cfg_o.font_bank    <= 1'b0;
        end else if (config_wr_i) begin
            case (config_num_i)
                video_pkg::REG_TEXT_START: begin
                    cfg_o.text_start <= config_data_i;  // full word address
                end
                video_pkg::REG_LINE_WIDTH: begin
                    cfg_o.line_width <= config_data_i;  // may exceed visible chars
                end
                video_pkg::REG_SCROLL: begin
                    cfg_o.fine_scrolly <= config_data_i[3:0];   // vertical only
                end
                video_pkg::REG_FONT: begin
                    cfg_o.font_height <= config_data_i[3:0];    // last line, not count
                    cfg_o.font_bank   <= config_data_i[8];
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_gen.sv
`default_nettype none
`timescale 1ns/1ns

module video_gen #(
    parameter int H_VISIBLE  = 64,                      // tiny mode keeps sims short
    parameter int H_FRONT    = 8,
    parameter int H_SYNC     = 8,
    parameter int H_BACK     = 16,
    parameter int V_VISIBLE  = 32,
    parameter int V_FRONT    = 2,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 4,
    parameter bit H_SYNC_POL = 1'b0,                    // active low
    parameter bit V_SYNC_POL = 1'b0
) (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     enable_i,
    input  wire                     config_wr_i,
    input  wire  [1:0]              config_num_i,
    input  wire  [15:0]             config_data_i,
    input  wire video_pkg::vram_word_t vram_data_i,
    input  wire video_pkg::font_byte_t font_data_i,
    output logic                    vram_sel_o,
    output video_pkg::vram_addr_t   vram_addr_o,
    output logic                    font_sel_o,
    output video_pkg::font_addr_t   font_addr_o,
    output logic [3:0]              red_o,
    output logic [3:0]              green_o,
    output logic [3:0]              blue_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);

    video_pkg::timing_ev_t ev;
    video_pkg::video_cfg_t cfg;
    video_pkg::rgb_t       rgb;
    logic                  text_en;
    logic                  pix;
    logic [7:0]            attr;

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (.clk(clk), .reset_i(reset_i), .events_o(ev));

    video_config_regs #(.RESET_LINE_WIDTH(H_VISIBLE / 8)) u_regs (
        .clk(clk), .reset_i(reset_i), .config_wr_i(config_wr_i),
        .config_num_i(config_num_i), .config_data_i(config_data_i), .cfg_o(cfg));

    text_fetch u_fetch (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .ev_i(ev), .cfg_i(cfg),
        .vram_data_i(vram_data_i), .font_data_i(font_data_i),
        .vram_sel_o(vram_sel_o), .font_sel_o(font_sel_o),
        .vram_addr_o(vram_addr_o), .font_addr_o(font_addr_o),
        .text_en_o(text_en), .pix_o(pix), .attr_o(attr));

    pixel_color #(.H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)) u_color (
        .clk(clk), .reset_i(reset_i), .ev_i(ev), .text_en_i(text_en), .pix_i(pix),
        .attr_i(attr), .rgb_o(rgb), .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o));

    assign red_o   = rgb.red;                           // split for the vga pins
    assign green_o = rgb.green;
    assign blue_o  = rgb.blue;

endmodule

`default_nettype wire

//--- verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [15:0] vram_addr_t;                   // video ram word address
    typedef logic [15:0] vram_word_t;                   // {bg, fg, char code}
    typedef logic [12:0] font_addr_t;                   // {bank, char code, font line}
    typedef logic  [7:0] font_byte_t;                   // leftmost pixel in bit 7
    typedef logic  [3:0] color_idx_t;                   // palette entry 0-15
    typedef logic [10:0] count_t;                       // h/v timing counter
    typedef logic  [3:0] font_line_t;                   // line inside a char cell

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // shared by both sync machines, stepped in this order
    typedef enum logic [1:0] {
        STATE_PRE_SYNC,
        STATE_SYNC,
        STATE_POST_SYNC,
        STATE_VISIBLE
    } video_state_e;

    typedef struct packed {
        vram_addr_t  text_start;                        // first char of the frame
        logic [15:0] line_width;                        // words per text row
        font_line_t  fine_scrolly;                      // first font line of the frame
        font_line_t  font_height;                       // last line of a char cell
        logic        font_bank;                         // upper or lower font half
    } video_cfg_t;

    typedef struct packed {
        logic hsync;                                    // h machine in sync, polarity not applied
        logic vsync;                                    // v machine in sync, polarity not applied
        logic visible;                                  // both machines visible
        logic line_end;                                 // last pixel of a line
        logic frame_end;                                // last pixel of a frame
        logic fetch;                                    // inside the fetch window
        logic fetch_start;                              // first clock of the fetch window
    } timing_ev_t;

    localparam logic [1:0] REG_TEXT_START = 2'd0;
    localparam logic [1:0] REG_LINE_WIDTH = 2'd1;
    localparam logic [1:0] REG_SCROLL     = 2'd2;
    localparam logic [1:0] REG_FONT       = 2'd3;

endpackage

`default_nettype wire

//--- verilog/video_timing.sv
`default_nettype none
`timescale 1ns/1ns

module video_timing #(
    parameter int H_VISIBLE = 64,
    parameter int H_FRONT   = 8,
    parameter int H_SYNC    = 8,
    parameter int H_BACK    = 16,
    parameter int V_VISIBLE = 32,
    parameter int V_FRONT   = 2,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 4
) (
    input  wire                     clk,
    input  wire                     reset_i,
    output video_pkg::timing_ev_t   events_o
);

    localparam int H_OFF   = H_FRONT + H_SYNC + H_BACK;                   // blanking sits left
    localparam int H_TOTAL = H_OFF + H_VISIBLE;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam video_pkg::count_t FETCH_BEGIN = video_pkg::count_t'(H_OFF - 9);   // one cell early
    localparam video_pkg::count_t FETCH_END   = video_pkg::count_t'(H_TOTAL - 9); // drain shifter

    video_pkg::video_state_e h_state;
    video_pkg::video_state_e v_state;
    video_pkg::count_t       h_count;
    video_pkg::count_t       v_count;
    video_pkg::count_t       h_last;                    // count that ends current h state
    video_pkg::count_t       v_last;                    // line that ends current v state
    logic                    line_end;
    logic                    frame_end;
    logic                    fetch;
    logic                    fetch_start;
    logic                    fetch_toggle;

    always_comb begin
        case (h_state)
            video_pkg::STATE_PRE_SYNC:  h_last = video_pkg::count_t'(H_FRONT - 1);
            video_pkg::STATE_SYNC:      h_last = video_pkg::count_t'(H_FRONT + H_SYNC - 1);
            video_pkg::STATE_POST_SYNC: h_last = video_pkg::count_t'(H_OFF - 1);
            video_pkg::STATE_VISIBLE:   h_last = video_pkg::count_t'(H_TOTAL - 1);
        endcase
        // visible lines first, blanking at the bottom
        case (v_state)
            video_pkg::STATE_VISIBLE:   v_last = video_pkg::count_t'(V_VISIBLE - 1);
            video_pkg::STATE_PRE_SYNC:  v_last = video_pkg::count_t'(V_VISIBLE + V_FRONT - 1);
            video_pkg::STATE_SYNC:      v_last = video_pkg::count_t'(V_TOTAL - V_BACK - 1);
            video_pkg::STATE_POST_SYNC: v_last = video_pkg::count_t'(V_TOTAL - 1);
        endcase
        line_end     = (h_state == video_pkg::STATE_VISIBLE) && (h_count == h_last);
        frame_end    = line_end && (v_state == video_pkg::STATE_POST_SYNC) && (v_count == v_last);
        fetch_toggle = (v_state == video_pkg::STATE_VISIBLE)
                       && (h_count == (fetch ? FETCH_END : FETCH_BEGIN)); // only on text lines
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state     <= video_pkg::STATE_PRE_SYNC;
            v_state     <= video_pkg::STATE_VISIBLE;
            h_count     <= '0;
            v_count     <= '0;
            fetch       <= 1'b0;
            fetch_start <= 1'b0;
        end else begin
            h_count <= line_end ? '0 : h_count + video_pkg::count_t'(1);
            if (h_count == h_last) begin
                h_state <= video_pkg::video_state_e'(h_state + 2'd1);   // visible wraps to pre-sync
            end
            if (line_end) begin
                v_count <= frame_end ? '0 : v_count + video_pkg::count_t'(1);
                if (v_count == v_last) begin
                    v_state <= video_pkg::video_state_e'(v_state + 2'd1);
                end
            end
            fetch       <= fetch ^ fetch_toggle;
            fetch_start <= fetch_toggle && !fetch;      // rising edge of window
        end
    end

    always_comb begin
        events_o.hsync       = (h_state == video_pkg::STATE_SYNC);
        events_o.vsync       = (v_state == video_pkg::STATE_SYNC);
        events_o.visible     = (h_state == video_pkg::STATE_VISIBLE)
                               && (v_state == video_pkg::STATE_VISIBLE);
        events_o.line_end    = line_end;
        events_o.frame_end   = frame_end;
        events_o.fetch       = fetch;
        events_o.fetch_start = fetch_start;
    end

    a_visible_in_range: assert property (@(posedge clk) disable iff (reset_i)
        events_o.visible |-> (h_count >= H_OFF && v_count < V_VISIBLE));
    a_frame_wraps: assert property (@(posedge clk) disable iff (reset_i)
        events_o.frame_end |=> (h_count == '0 && v_count == '0
                                && h_state == video_pkg::STATE_PRE_SYNC
                                && v_state == video_pkg::STATE_VISIBLE));

endmodule

`default_nettype wire
